//--- sources.f
capture_buffer_pkg.sv
sample_router.sv
bank_write_control.sv
bank_memory.sv
capture_buffer.sv
tb_clock_gen.sv
capture_buffer_props.sv
capture_buffer_tb.sv

//--- Bender.yml
package:
  name: capture_buffer

sources:
  - capture_buffer_pkg.sv
  - sample_router.sv
  - bank_write_control.sv
  - bank_memory.sv
  - capture_buffer.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - capture_buffer_props.sv
      - capture_buffer_tb.sv

//--- capture_buffer_tb.sv
// capture buffer testbench
// directed capture, chaining, gating and readback tests against a reference model

`timescale 1ns/100ps

module capture_buffer_tb;

  localparam int BUFFER_DEPTH = 16;
  localparam int CHANNELS = capture_buffer_pkg::CHANNELS;
  localparam int DRIVE_DELAY = 10;
  // tests take about 560 cycles in all and the limit sits well above that
  localparam int TIMEOUT_CYCLES = 2000;

  logic capture_clk;
  logic capture_reset;
  capture_buffer_pkg::lanes_t capture_data;
  capture_buffer_pkg::mode_t capture_banking_mode;
  logic capture_start;
  logic capture_stop;
  logic capture_sw_reset;
  capture_buffer_pkg::read_req_t read_req;
  logic capture_full;
  capture_buffer_pkg::addr_t [CHANNELS-1:0] capture_write_addr;
  capture_buffer_pkg::read_rsp_t read_rsp;

  //////////////////////////////////////////////////////////////////////
  // reference model state
  //////////////////////////////////////////////////////////////////////

  capture_buffer_pkg::sample_t ref_mem [CHANNELS][BUFFER_DEPTH];
  bit ref_written [CHANNELS][BUFFER_DEPTH];
  capture_buffer_pkg::addr_t ref_addr [CHANNELS];
  bit [CHANNELS-1:0] ref_mask;
  bit ref_full;
  capture_buffer_pkg::mode_t ref_mode;

  integer seed;
  int error_count;
  int test_errors;
  int check_count;
  int test_count;
  int cycle_count;

  tb_clock_gen #(.PERIOD(100)) u_clock_gen (.capture_clk(capture_clk));

  capture_buffer #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) DUT (
    .capture_clk          (capture_clk),
    .capture_reset        (capture_reset),
    .capture_data         (capture_data),
    .capture_banking_mode (capture_banking_mode),
    .capture_start        (capture_start),
    .capture_stop         (capture_stop),
    .capture_sw_reset     (capture_sw_reset),
    .read_req             (read_req),
    .capture_full         (capture_full),
    .capture_write_addr   (capture_write_addr),
    .read_rsp             (read_rsp)
  );

  // run limit
  always @(posedge capture_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sample(input string name, input capture_buffer_pkg::sample_t actual,
                              input capture_buffer_pkg::sample_t expected);
    check_count++;
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h expected %h", name, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_addr(input string name, input capture_buffer_pkg::addr_t actual,
                            input capture_buffer_pkg::addr_t expected);
    check_count++;
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h expected %h", name, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input bit actual, input bit expected);
    check_count++;
    if (actual !== expected) begin
      $display("[FAIL] %s: got %h expected %h", name, actual, expected);
      error_count++;
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // model and stimulus
  //////////////////////////////////////////////////////////////////////

  // inputs change a short delay after the rising edge
  task automatic wait_cycle();
    @(posedge capture_clk);
    #DRIVE_DELAY;
  endtask

  // bank c takes lane c mod 2^mode, then hands the chain 2^mode banks up
  task automatic model_sample(input capture_buffer_pkg::lanes_t lanes);
    bit [CHANNELS-1:0] take;
    int step;
    int lane;
    step = 1 << ref_mode;
    for (int c = 0; c < CHANNELS; c++) begin
      lane = c % step;
      take[c] = capture_start && !capture_stop && ref_mask[c] && lanes.valid[lane];
    end
    for (int c = 0; c < CHANNELS; c++) begin
      if (take[c]) begin
        ref_mem[c][ref_addr[c]] = lanes.data[c % step];
        ref_written[c][ref_addr[c]] = 1'b1;
        if (ref_addr[c] == BUFFER_DEPTH - 1) begin
          ref_mask[c] = 1'b0;
          if (c + step < CHANNELS) begin
            ref_mask[c + step] = 1'b1;
          end else begin
            ref_full = 1'b1;
          end
        end else begin
          ref_addr[c] = ref_addr[c] + 1'b1;
        end
      end
    end
  endtask

  task automatic drive_sample(input logic [CHANNELS-1:0] valid);
    capture_buffer_pkg::lanes_t lanes;
    lanes.valid = valid;
    for (int c = 0; c < CHANNELS; c++) begin
      lanes.data[c] = capture_buffer_pkg::sample_t'($random(seed));
    end
    capture_data = lanes;
    model_sample(lanes);
    wait_cycle();
  endtask

  task automatic idle(input int cycles);
    capture_data.valid = '0;
    repeat (cycles) wait_cycle();
  endtask

  // start low for a cycle so the next rise is an edge
  task automatic start_capture(input capture_buffer_pkg::mode_t mode);
    capture_data.valid = '0;
    capture_start = 1'b0;
    wait_cycle();
    capture_banking_mode = mode;
    capture_start = 1'b1;
    ref_mode = mode;
    for (int c = 0; c < CHANNELS; c++) begin
      ref_mask[c] = c < (1 << mode);
    end
    wait_cycle();
  endtask

  task automatic capture_run(input capture_buffer_pkg::mode_t mode, input int count);
    start_capture(mode);
    repeat (count) drive_sample('1);
    idle(4);
  endtask

  task automatic sw_reset();
    capture_data.valid = '0;
    capture_start = 1'b0;
    capture_sw_reset = 1'b1;
    wait_cycle();
    capture_sw_reset = 1'b0;
    for (int c = 0; c < CHANNELS; c++) begin
      ref_addr[c] = '0;
    end
    ref_mask = '0;
    ref_full = 1'b0;
    wait_cycle();
  endtask

  // one strobe per cycle, response checked the cycle after
  task automatic read_bank(input int channel);
    for (int a = 0; a < BUFFER_DEPTH; a++) begin
      read_req.strobe = 1'b1;
      read_req.channel = channel[capture_buffer_pkg::CHANNEL_WIDTH-1:0];
      read_req.addr = capture_buffer_pkg::addr_t'(a);
      wait_cycle();
      check_flag("read_rsp.valid", read_rsp.valid, 1'b1);
      if (ref_written[channel][a]) begin
        check_sample($sformatf("read_rsp.data bank %0d word %0d", channel, a),
                     read_rsp.data, ref_mem[channel][a]);
      end
    end
    read_req.strobe = 1'b0;
    wait_cycle();
    check_flag("read_rsp.valid idle", read_rsp.valid, 1'b0);
  endtask

  task automatic check_status();
    for (int c = 0; c < CHANNELS; c++) begin
      check_addr($sformatf("capture_write_addr[%0d]", c), capture_write_addr[c], ref_addr[c]);
    end
    check_flag("capture_full", capture_full, ref_full);
  endtask

  task automatic read_all_banks();
    for (int c = 0; c < CHANNELS; c++) begin
      read_bank(c);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d errors", test_count, name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    check_status();
    check_flag("read_rsp.valid before strobe", read_rsp.valid, 1'b0);
    read_req.strobe = 1'b1;
    wait_cycle();
    read_req.strobe = 1'b0;
    check_flag("read_rsp.valid after strobe", read_rsp.valid, 1'b1);
    wait_cycle();
    check_flag("read_rsp.valid second cycle", read_rsp.valid, 1'b0);
    finish_test("reset state");
  endtask

  task automatic test_four_lanes();
    capture_run(2, 10);
    check_status();
    read_all_banks();
    finish_test("four lanes");
  endtask

  // one lane walks banks 0 to 3, full three cycles after the last sample
  task automatic test_one_lane();
    sw_reset();
    start_capture(0);
    repeat (4 * BUFFER_DEPTH) drive_sample('1);
    check_flag("capture_full one cycle after", capture_full, 1'b0);
    idle(1);
    check_flag("capture_full two cycles after", capture_full, 1'b0);
    idle(1);
    check_flag("capture_full three cycles after", capture_full, ref_full);
    repeat (8) drive_sample('1);
    idle(4);
    check_status();
    read_all_banks();
    finish_test("one lane chain");
  endtask

  // lane 0 over banks 0 and 2, lane 1 over banks 1 and 3
  task automatic test_two_lanes();
    sw_reset();
    capture_run(1, 20);
    check_status();
    repeat (6) drive_sample(4'b0001);
    idle(4);
    check_status();
    read_all_banks();
    repeat (6) drive_sample(4'b0001);
    idle(4);
    check_status();
    read_bank(2);
    finish_test("two lane chains");
  endtask

  task automatic test_sw_reset();
    check_flag("capture_full before sw reset", capture_full, 1'b1);
    sw_reset();
    check_status();
    capture_run(2, 3);
    check_status();
    read_all_banks();
    finish_test("software reset");
  endtask

  task automatic test_gating();
    sw_reset();
    // start still low, nothing armed
    repeat (4) drive_sample('1);
    idle(3);
    check_status();
    start_capture(2);
    repeat (6) drive_sample(CHANNELS'($random(seed)));
    repeat (2) drive_sample('0);
    capture_stop = 1'b1;
    repeat (4) drive_sample('1);
    capture_stop = 1'b0;
    // mode input moves without a start edge
    capture_banking_mode = 0;
    repeat (4) drive_sample('1);
    idle(4);
    check_status();
    read_all_banks();
    finish_test("gating");
  endtask

  initial begin
    seed = 32'hf60b;
    error_count = 0;
    test_errors = 0;
    check_count = 0;
    test_count = 0;
    cycle_count = 0;
    capture_reset = 1'b1;
    capture_data = '0;
    capture_banking_mode = '0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    capture_sw_reset = 1'b0;
    read_req = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      ref_addr[c] = '0;
      for (int a = 0; a < BUFFER_DEPTH; a++) begin
        ref_written[c][a] = 1'b0;
      end
    end
    ref_mask = '0;
    ref_full = 1'b0;
    ref_mode = '0;

    repeat (8) @(posedge capture_clk);
    #DRIVE_DELAY;
    capture_reset = 1'b0;
    wait_cycle();

    test_reset_state();
    test_four_lanes();
    test_one_lane();
    test_two_lanes();
    test_sw_reset();
    test_gating();

    $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- capture_buffer_props.sv
// capture buffer controller properties
// one enabled bank per chain, addresses stay in range, full is sticky

`timescale 1ns/100ps

module capture_buffer_props #(
  parameter int BUFFER_DEPTH = 16
) (
  input logic capture_clk,
  input logic capture_reset,
  input logic capture_sw_reset,
  input capture_buffer_pkg::mode_t mode,
  input logic [capture_buffer_pkg::CHANNELS-1:0] valid_mask,
  input logic [capture_buffer_pkg::CHANNELS-1:0] write_enable,
  input capture_buffer_pkg::addr_t [capture_buffer_pkg::CHANNELS-1:0] capture_write_addr,
  input logic capture_full
);

  logic addr_in_range;
  logic chain_clash;

  // every bank address at or below the last word
  always_comb begin
    addr_in_range = 1'b1;
    for (int c = 0; c < capture_buffer_pkg::CHANNELS; c++) begin
      if (capture_write_addr[c] > BUFFER_DEPTH - 1) begin
        addr_in_range = 1'b0;
      end
    end
  end

  // an enabled bank must hold the only mask bit of its chain
  // banks share a chain when they sit a multiple of 2^mode apart
  always_comb begin
    chain_clash = 1'b0;
    for (int c = 0; c < capture_buffer_pkg::CHANNELS; c++) begin
      for (int d = 0; d < capture_buffer_pkg::CHANNELS; d++) begin
        if (d != c && write_enable[c] && valid_mask[d]
            && ((d - c) % (1 << mode)) == 0) begin
          chain_clash = 1'b1;
        end
      end
    end
  end

  enable_in_mask: assert property (
    @(posedge capture_clk) disable iff (capture_reset)
      !chain_clash
  ) else $error("write enable set while another bank of the same chain holds the mask");

  addr_bounded: assert property (
    @(posedge capture_clk) disable iff (capture_reset)
      addr_in_range
  ) else $error("bank write address beyond the last word");

  // full only drops after a software or hardware reset
  full_sticky: assert property (
    @(posedge capture_clk) disable iff (capture_reset)
      $fell(capture_full) |-> $past(capture_sw_reset || capture_reset)
  ) else $error("capture_full fell without a reset");

endmodule

bind bank_write_control capture_buffer_props #(
  .BUFFER_DEPTH (BUFFER_DEPTH)
) u_capture_buffer_props (
  .capture_clk        (capture_clk),
  .capture_reset      (capture_reset),
  .capture_sw_reset   (capture_sw_reset),
  .mode               (mode_reg),
  .valid_mask         (valid_mask),
  .write_enable       (write_enable),
  .capture_write_addr (write_addr),
  .capture_full       (capture_full)
);

//--- tb_clock_gen.sv
// testbench clock source
// free-running capture clock

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic capture_clk
);

  initial begin
    capture_clk = 1'b0;
  end

  // half period high, half period low
  always begin
    #(PERIOD / 2);
    capture_clk = ~capture_clk;
  end

endmodule

//--- capture_buffer.sv
// capture buffer top
// sample router and bank write controller feeding the per-channel bank memory

`timescale 1ns/100ps

module capture_buffer #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic capture_clk,
  input  logic capture_reset,
  input  capture_buffer_pkg::lanes_t capture_data,
  input  capture_buffer_pkg::mode_t capture_banking_mode,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic capture_sw_reset,
  input  capture_buffer_pkg::read_req_t read_req,
  output logic capture_full,
  output capture_buffer_pkg::addr_t [capture_buffer_pkg::CHANNELS-1:0] capture_write_addr,
  output capture_buffer_pkg::read_rsp_t read_rsp
);

  // routed samples, write controls and the latched mode
  capture_buffer_pkg::sample_t [capture_buffer_pkg::CHANNELS-1:0] bank_data;
  capture_buffer_pkg::bank_write_t bank_write;
  capture_buffer_pkg::mode_t mode;

  // data path, two registers deep
  sample_router u_sample_router (
    .capture_clk   (capture_clk),
    .capture_reset (capture_reset),
    .capture_data  (capture_data),
    .mode          (mode),
    .bank_data     (bank_data)
  );

  // control path, only the valid bits of the lanes
  bank_write_control #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) u_bank_write_control (
    .capture_clk          (capture_clk),
    .capture_reset        (capture_reset),
    .capture_valid        (capture_data.valid),
    .capture_banking_mode (capture_banking_mode),
    .capture_start        (capture_start),
    .capture_stop         (capture_stop),
    .capture_sw_reset     (capture_sw_reset),
    .mode                 (mode),
    .bank_write           (bank_write),
    .capture_write_addr   (capture_write_addr),
    .capture_full         (capture_full)
  );

  bank_memory #(
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) u_bank_memory (
    .capture_clk (capture_clk),
    .bank_write  (bank_write),
    .bank_data   (bank_data),
    .read_req    (read_req),
    .read_rsp    (read_rsp)
  );

endmodule

//--- bank_memory.sv
// bank memory
// one sample array per channel with a write port per bank and one registered read port

`timescale 1ns/100ps

module bank_memory #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic capture_clk,
  input  capture_buffer_pkg::bank_write_t bank_write,
  input  capture_buffer_pkg::sample_t [capture_buffer_pkg::CHANNELS-1:0] bank_data,
  input  capture_buffer_pkg::read_req_t read_req,
  output capture_buffer_pkg::read_rsp_t read_rsp
);

  localparam int CHANNELS = capture_buffer_pkg::CHANNELS;
  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  // registered read word of every bank
  capture_buffer_pkg::sample_t [CHANNELS-1:0] bank_rd;

  //////////////////////////////////////////////////////////////////////
  // storage banks
  //////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < CHANNELS; c++) begin : g_bank
    capture_buffer_pkg::sample_t mem [BUFFER_DEPTH];

    // write side, address already aligned with the routed sample
    always_ff @(posedge capture_clk) begin
      if (bank_write.enable[c]) begin
        mem[bank_write.addr[c][ADDR_WIDTH-1:0]] <= bank_data[c];
      end
    end

    // read side, every bank reads, channel picks one afterwards
    always_ff @(posedge capture_clk) begin
      if (read_req.strobe) begin
        bank_rd[c] <= mem[read_req.addr[ADDR_WIDTH-1:0]];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read response
  //////////////////////////////////////////////////////////////////////

  logic rsp_valid;
  logic [capture_buffer_pkg::CHANNEL_WIDTH-1:0] rsp_channel;

  // valid follows the strobe by exactly one cycle
  always_ff @(posedge capture_clk) begin
    rsp_valid <= read_req.strobe;
    if (read_req.strobe) begin
      rsp_channel <= read_req.channel;
    end
  end

  assign read_rsp = '{valid: rsp_valid, data: bank_rd[rsp_channel]};

endmodule

//--- bank_write_control.sv
// bank write controller
// start edge and mode latch, bank chaining mask, write addresses, sticky full

`timescale 1ns/100ps

module bank_write_control #(
  parameter int BUFFER_DEPTH = 16
) (
  input  logic capture_clk,
  input  logic capture_reset,
  input  logic [capture_buffer_pkg::CHANNELS-1:0] capture_valid,
  input  capture_buffer_pkg::mode_t capture_banking_mode,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic capture_sw_reset,
  output capture_buffer_pkg::mode_t mode,
  output capture_buffer_pkg::bank_write_t bank_write,
  output capture_buffer_pkg::addr_t [capture_buffer_pkg::CHANNELS-1:0] capture_write_addr,
  output logic capture_full
);

  localparam int CHANNELS = capture_buffer_pkg::CHANNELS;
  localparam capture_buffer_pkg::addr_t LAST_ADDR =
    capture_buffer_pkg::addr_t'(BUFFER_DEPTH - 1);

  //////////////////////////////////////////////////////////////////////
  // start edge, arming and mode latch
  //////////////////////////////////////////////////////////////////////

  logic start_reg;
  logic start_edge;
  logic armed_reg;
  logic [CHANNELS-1:0] valid_reg;
  capture_buffer_pkg::mode_t mode_reg;
  capture_buffer_pkg::mode_t mode_next;

  assign start_edge = capture_start & ~start_reg;
  // out-of-range modes fold to all lanes independent
  assign mode_next = (capture_banking_mode > capture_buffer_pkg::MAX_MODE) ?
                     capture_buffer_pkg::MAX_MODE : capture_banking_mode;

  // valid and arm state line up with the router's input register
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      start_reg <= 1'b0;
      armed_reg <= 1'b0;
      valid_reg <= '0;
      mode_reg <= '0;
    end else begin
      start_reg <= capture_start;
      armed_reg <= capture_start & ~capture_stop;
      valid_reg <= capture_valid;
      if (start_edge) begin
        mode_reg <= mode_next;
      end
    end
  end

  assign mode = mode_reg;

  //////////////////////////////////////////////////////////////////////
  // write enables and chaining
  //////////////////////////////////////////////////////////////////////

  logic [CHANNELS-1:0] valid_mask;
  logic [CHANNELS-1:0] bank_done;
  logic [CHANNELS-1:0] write_enable;
  logic [CHANNELS-1:0] bank_last;
  logic [CHANNELS-1:0] has_next;
  capture_buffer_pkg::addr_t [CHANNELS-1:0] write_addr;

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      // bank takes its lane's sample only while it owns the chain
      write_enable[c] = armed_reg & valid_mask[c] & ~bank_done[c]
                        & valid_reg[capture_buffer_pkg::lane_of(c, mode_reg)];
      bank_last[c] = write_enable[c] & (write_addr[c] == LAST_ADDR);
      // successor sits 2^mode banks higher
      has_next[c] = (c + (1 << mode_reg)) < CHANNELS;
    end
  end

  // mask seeds the lowest 2^mode banks, then walks up the chain
  always_ff @(posedge capture_clk) begin
    if (capture_reset || capture_sw_reset) begin
      valid_mask <= '0;
    end else if (start_edge) begin
      for (int c = 0; c < CHANNELS; c++) begin
        valid_mask[c] <= c < (1 << mode_next);
      end
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (bank_last[c]) begin
          valid_mask[c] <= 1'b0;
          if (has_next[c]) begin
            valid_mask[c + (1 << mode_reg)] <= 1'b1;
          end
        end
      end
    end
  end

  // next free address, parks at the last word once the bank is done
  always_ff @(posedge capture_clk) begin
    if (capture_reset || capture_sw_reset) begin
      write_addr <= '0;
      bank_done <= '0;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (write_enable[c] && !bank_last[c]) begin
          write_addr[c] <= write_addr[c] + 1'b1;
        end
        if (bank_last[c]) begin
          bank_done[c] <= 1'b1;
        end
      end
    end
  end

  assign capture_write_addr = write_addr;

  //////////////////////////////////////////////////////////////////////
  // write port delay and sticky full
  //////////////////////////////////////////////////////////////////////

  logic [CHANNELS-1:0] enable_d;
  capture_buffer_pkg::addr_t [CHANNELS-1:0] addr_d;
  logic chain_end_d;

  // one extra cycle to meet the routed data
  always_ff @(posedge capture_clk) begin
    addr_d <= write_addr;
    if (capture_reset) begin
      enable_d <= '0;
    end else begin
      enable_d <= write_enable;
    end
  end

  assign bank_write = '{enable: enable_d, addr: addr_d};

  // full lands together with the final bank's last write
  always_ff @(posedge capture_clk) begin
    if (capture_reset || capture_sw_reset) begin
      chain_end_d <= 1'b0;
      capture_full <= 1'b0;
    end else begin
      chain_end_d <= |(bank_last & ~has_next);
      if (chain_end_d) begin
        capture_full <= 1'b1;
      end
    end
  end

endmodule

//--- sample_router.sv
// sample router
// registers the input lanes and steers one lane onto each bank's write data

`timescale 1ns/100ps

module sample_router (
  input  logic capture_clk,
  input  logic capture_reset,
  input  capture_buffer_pkg::lanes_t capture_data,
  input  capture_buffer_pkg::mode_t mode,
  output capture_buffer_pkg::sample_t [capture_buffer_pkg::CHANNELS-1:0] bank_data
);

  localparam int CHANNELS = capture_buffer_pkg::CHANNELS;

  //////////////////////////////////////////////////////////////////////
  // stage 1, input register
  //////////////////////////////////////////////////////////////////////

  // raw lane samples, one cycle behind the ports
  capture_buffer_pkg::sample_t [CHANNELS-1:0] data_reg;

  always_ff @(posedge capture_clk) begin
    data_reg <= capture_data.data;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, lane to bank routing
  //////////////////////////////////////////////////////////////////////

  // mode comes from the controller latch, so both sides
  // agree on which lane feeds which bank
  // mode 0: every bank sees lane 0
  // mode 1: banks 0,2 see lane 0 and banks 1,3 see lane 1
  // mode 2: bank c sees lane c
  always_ff @(posedge capture_clk) begin
    if (capture_reset) begin
      bank_data <= '0;
    end else begin
      for (int c = 0; c < CHANNELS; c++) begin
        bank_data[c] <= data_reg[capture_buffer_pkg::lane_of(c, mode)];
      end
    end
  end

endmodule

//--- capture_buffer_pkg.sv
// capture buffer shared definitions
// lane and bank sizes, address and sample types, inter-block bundles

package capture_buffer_pkg;

  // lanes in, banks out (one bank per lane)
  localparam int CHANNELS = 4;
  localparam int CHANNEL_WIDTH = $clog2(CHANNELS);
  localparam int DATA_WIDTH = 16;
  // deepest bank the address type can reach
  localparam int MAX_DEPTH = 64;

  // banking mode, 2^mode active lanes
  typedef logic [1:0] mode_t;
  typedef logic [$clog2(MAX_DEPTH)-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] sample_t;

  // highest legal mode, every lane independent
  localparam mode_t MAX_MODE = mode_t'(CHANNEL_WIDTH);

  // parallel input lanes
  typedef struct packed {
    logic [CHANNELS-1:0] valid;
    sample_t [CHANNELS-1:0] data;
  } lanes_t;

  // per-bank write enable and address, controller to memory
  typedef struct packed {
    logic [CHANNELS-1:0] enable;
    addr_t [CHANNELS-1:0] addr;
  } bank_write_t;

  // software read port
  typedef struct packed {
    logic strobe;
    logic [CHANNEL_WIDTH-1:0] channel;
    addr_t addr;
  } read_req_t;

  typedef struct packed {
    logic valid;
    sample_t data;
  } read_rsp_t;

  // lane feeding a bank: channel mod active lane count
  function automatic logic [CHANNEL_WIDTH-1:0] lane_of(input int channel, input mode_t mode);
    logic [CHANNEL_WIDTH-1:0] lane_mask;
    lane_mask = CHANNEL_WIDTH'((1 << mode) - 1);
    return CHANNEL_WIDTH'(channel) & lane_mask;
  endfunction

endpackage
